//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int wordWidth = 16;
	localparam int addrWidth = 3;
	localparam int numRegs = 8;

	typedef logic [wordWidth-1:0] word;
	typedef logic [addrWidth-1:0] regAddr;

	localparam regAddr linkReg = 3'd7; // Return address register

	typedef enum logic [1:0] {
		sext5,
		sext8,
		sext11,
		zext
	} immSel;

	// Branch conditions tested on the forwarded Rs value
	typedef enum logic [1:0] {
		eqz,
		nez,
		ltz,
		gez
	} flagCond;

	typedef enum logic [1:0] {
		dstRd,    // Bits 7:5
		dstRdAlt, // Bits 4:2
		dstRs,    // Bits 10:8
		dstLink
	} destSel;

	typedef struct packed {
		logic   wrEn;
		regAddr addr;
		word    data;
	} wbPort;

	typedef struct packed {
		immSel   imm;
		logic    zeroExt8;
		destSel  dest;
		flagCond cond;
		logic    operandBImm;
		logic    forwardRs;
		logic    forwardRt;
		logic    branch;
		logic    jump;
		logic    pcBaseNext;  // Next PC as branch base instead of Rs
		logic    branchImm11;
	} decodeCtrl;

	typedef struct packed {
		word    rsData;
		word    operandB;
		word    imm;
		word    instr;
		regAddr destReg;
		word    nextPc;
	} decodeOut;

endpackage

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input  logic           clk,
	input  logic           reset,
	input  cpuPkg::regAddr rdAddrA,
	input  cpuPkg::regAddr rdAddrB,
	input  cpuPkg::wbPort  wb,
	output cpuPkg::word    rdDataA,
	output cpuPkg::word    rdDataB
);

	import cpuPkg::*;

	word regs [numRegs];

	// One write port, fed by writeback
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.wrEn) begin
			regs[wb.addr] <= wb.data;
		end
	end

	// Asynchronous reads with no write bypass
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

`default_nettype wire

//--- rtl/immExtend.sv
`timescale 1ns/10ps
`default_nettype none

module immExtend (
	input  cpuPkg::word   instr,
	input  cpuPkg::immSel sel,
	input  logic          zeroExt8,
	output cpuPkg::word   imm
);

	import cpuPkg::*;

	word sext5Val;
	word sext8Val;
	word sext11Val;
	word zextVal;

	assign sext5Val  = {{11{instr[4]}}, instr[4:0]};
	assign sext8Val  = {{8{instr[7]}}, instr[7:0]};
	assign sext11Val = {{5{instr[10]}}, instr[10:0]};

	// Byte or nibble chosen by zeroExt8
	assign zextVal = zeroExt8 ? {8'd0, instr[7:0]} : {12'd0, instr[3:0]};

	always_comb begin
		case (sel)
			sext5:   imm = sext5Val;
			sext8:   imm = sext8Val;
			sext11:  imm = sext11Val;
			zext:    imm = zextVal;
			default: imm = sext5Val;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/branchResolve.sv
`timescale 1ns/10ps
`default_nettype none

module branchResolve (
	input  cpuPkg::word     instr,
	input  cpuPkg::word     nextPc,
	input  cpuPkg::word     rsData,
	input  cpuPkg::word     rsReg,
	input  cpuPkg::flagCond cond,
	input  logic            branch,
	input  logic            jump,
	input  logic            pcBaseNext,
	input  logic            branchImm11,
	output cpuPkg::word     truePc
);

	import cpuPkg::*;

	logic dataZero;
	logic dataNeg;
	logic condMet;
	logic taken;
	word  offset;
	word  base;
	word  target;

	assign dataZero = ~|rsData;
	assign dataNeg  = rsData[15];

	always_comb begin
		case (cond)
			eqz:     condMet = dataZero;
			nez:     condMet = ~dataZero;
			ltz:     condMet = dataNeg;  // Sign bit set
			gez:     condMet = ~dataNeg; // Includes zero
			default: condMet = 1'b0;
		endcase
	end

	// Signed offset of 11 or 8 bits
	assign offset = branchImm11 ? {{5{instr[10]}}, instr[10:0]}
	                            : {{8{instr[7]}}, instr[7:0]};

	// Register base comes straight from the register file
	assign base = pcBaseNext ? nextPc : rsReg;

	assign target = base + offset;

	assign taken = jump | (branch & condMet);

	assign truePc = taken ? target : nextPc;

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
	input  logic              clk,
	input  logic              reset,
	input  cpuPkg::word       instr,
	input  cpuPkg::word       nextPc,
	input  cpuPkg::word       rsFwd,
	input  cpuPkg::word       rtFwd,
	input  cpuPkg::decodeCtrl ctrl,
	input  cpuPkg::wbPort     wb,
	output cpuPkg::decodeOut  out,
	output cpuPkg::word       truePc
);

	import cpuPkg::*;

	regAddr rsAddr;
	regAddr rtAddr;
	regAddr rdAltAddr;
	regAddr destReg;
	word    rsReg;
	word    rtReg;
	word    rsData;
	word    rtData;
	word    imm;
	word    operandB;

	// Instruction fields
	assign rsAddr    = instr[10:8];
	assign rtAddr    = instr[7:5];
	assign rdAltAddr = instr[4:2];

	regFile regFile_inst (
		.clk     (clk),
		.reset   (reset),
		.rdAddrA (rsAddr),
		.rdAddrB (rtAddr),
		.wb      (wb),
		.rdDataA (rsReg),
		.rdDataB (rtReg)
	);

	// Forwarding overrides from later stages
	assign rsData = ctrl.forwardRs ? rsFwd : rsReg;
	assign rtData = ctrl.forwardRt ? rtFwd : rtReg;

	immExtend immExtend_inst (
		.instr    (instr),
		.sel      (ctrl.imm),
		.zeroExt8 (ctrl.zeroExt8),
		.imm      (imm)
	);

	assign operandB = ctrl.operandBImm ? imm : rtData;

	always_comb begin
		case (ctrl.dest)
			dstRd:    destReg = rtAddr;
			dstRdAlt: destReg = rdAltAddr;
			dstRs:    destReg = rsAddr;
			dstLink:  destReg = linkReg;
			default:  destReg = rtAddr;
		endcase
	end

	branchResolve branchResolve_inst (
		.instr       (instr),
		.nextPc      (nextPc),
		.rsData      (rsData),
		.rsReg       (rsReg), // Unforwarded base for register jumps
		.cond        (ctrl.cond),
		.branch      (ctrl.branch),
		.jump        (ctrl.jump),
		.pcBaseNext  (ctrl.pcBaseNext),
		.branchImm11 (ctrl.branchImm11),
		.truePc      (truePc)
	);

	always_comb begin
		out          = '0;
		out.rsData   = rsData;
		out.operandB = operandB;
		out.imm      = imm;
		out.instr    = instr;  // Pass through to execute
		out.destReg  = destReg;
		out.nextPc   = nextPc;
	end

endmodule

`default_nettype wire

//--- bench/decodeStage_props.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage_props (
	input logic              clk,
	input cpuPkg::word       nextPc,
	input cpuPkg::decodeCtrl ctrl,
	input cpuPkg::decodeOut  out,
	input cpuPkg::word       truePc
);

	import cpuPkg::*;

	int   failCount = 0;
	logic sextOk;

	// Upper bits copy the top bit of the chosen field
	always_comb begin
		case (ctrl.imm)
			sext5:   sextOk = out.imm[15:5] == {11{out.imm[4]}};
			sext8:   sextOk = out.imm[15:8] == {8{out.imm[7]}};
			sext11:  sextOk = out.imm[15:11] == {5{out.imm[10]}};
			default: sextOk = 1'b1;
		endcase
	end

	noJumpPc: assert property (@(posedge clk)
		!(ctrl.branch || ctrl.jump) |-> truePc == nextPc)
		else begin
			failCount++;
			$error("truePc left nextPc with no branch or jump");
		end

	sextFill: assert property (@(posedge clk) sextOk)
		else begin
			failCount++;
			$error("Sign extension fill is wrong for imm %h", out.imm);
		end

	zextFill: assert property (@(posedge clk)
		ctrl.imm == zext |-> out.imm[15:8] == 8'd0 && (ctrl.zeroExt8 || out.imm[7:4] == 4'd0))
		else begin
			failCount++;
			$error("Zero extension left upper bits set in imm %h", out.imm);
		end

	linkDest: assert property (@(posedge clk) ctrl.dest == dstLink |-> out.destReg == linkReg)
		else begin
			failCount++;
			$error("destReg is %0d under dstLink", out.destReg);
		end

endmodule

bind decodeStage decodeStage_props propsInst (.*);

`default_nettype wire

//--- bench/decodeStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb;

	import cpuPkg::*;

	localparam int clkPeriod = 20;
	localparam int numFields = 20; // Columns of a decode line

	typedef struct packed {
		logic      isWrite;
		wbPort     wb;
		word       instr;
		word       nextPc;
		decodeCtrl ctrl;
		word       rsFwd;
		word       rtFwd;
		word       expRs;
		word       expOperandB;
		word       expImm;
		regAddr    expDest;
		word       expPc;
	} caseRec;

	logic      clk;
	logic      reset;
	word       instr;
	word       nextPc;
	word       rsFwd;
	word       rtFwd;
	decodeCtrl ctrl;
	wbPort     wb;
	decodeOut  out;
	word       truePc;
	caseRec    cases[$];
	logic      loaded = 1'b0;

	decodeStage decodeStage_inst (
		.clk    (clk),
		.reset  (reset),
		.instr  (instr),
		.nextPc (nextPc),
		.rsFwd  (rsFwd),
		.rtFwd  (rtFwd),
		.ctrl   (ctrl),
		.wb     (wb),
		.out    (out),
		.truePc (truePc)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic failRun();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkWord(input word got, input word exp, input string label);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, label, got, exp);
			failRun();
		end
	endtask

	task automatic checkReg(input regAddr got, input regAddr exp, input string label);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, label, got, exp);
			failRun();
		end
	endtask

	task automatic readCases();
		int          fd;
		int          n;
		int          want;
		string       tok;
		string       rest;
		logic [15:0] v;
		logic [15:0] fld [numFields];
		caseRec      rec;
		fd = $fopen("bench/decodeCases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the case file bench/decodeCases.txt");
			failRun();
		end else begin
			while (!$feof(fd)) begin
				rec = '0;
				n = 0;
				if ($fscanf(fd, "%s", tok) == 1) begin
					if (tok.getc(0) == "#") begin
						n = $fgets(rest, fd); // Comment line
					end else if (tok == "W" || tok == "D") begin
						rec.isWrite = (tok == "W");
						want = rec.isWrite ? 2 : numFields;
						for (int k = 0; k < want; k++) begin
							n += $fscanf(fd, "%h", v);
							fld[k] = v;
						end
						if (n != want) begin
							$display("Malformed line in the case file after %0d cases",
								cases.size());
							failRun();
						end else begin
							if (rec.isWrite) begin
								rec.wb.wrEn = 1'b1;
								rec.wb.addr = fld[0][2:0];
								rec.wb.data = fld[1];
							end else begin
								rec.instr  = fld[0];
								rec.nextPc = fld[1];
								// Columns follow the field order of decodeCtrl
								rec.ctrl = {fld[2][1:0], fld[3][0], fld[4][1:0], fld[5][1:0],
									fld[6][0], fld[7][0], fld[8][0], fld[9][0], fld[10][0],
									fld[11][0], fld[12][0]};
								rec.rsFwd       = fld[13];
								rec.rtFwd       = fld[14];
								rec.expRs       = fld[15];
								rec.expOperandB = fld[16];
								rec.expImm      = fld[17];
								rec.expDest     = fld[18][2:0];
								rec.expPc       = fld[19];
							end
							cases.push_back(rec);
						end
					end else begin
						$display("Unknown line type %s in the case file", tok);
						failRun();
					end
				end
			end
			$fclose(fd);
			if (cases.size() == 0) begin
				$display("The case file holds no cases");
				failRun();
			end
		end
	endtask

	task automatic applyCase(input caseRec c);
		if (c.isWrite) begin
			wb = c.wb;
		end else begin
			wb     = '0;
			instr  = c.instr;
			nextPc = c.nextPc;
			ctrl   = c.ctrl;
			rsFwd  = c.rsFwd;
			rtFwd  = c.rtFwd;
		end
	endtask

	task automatic checkCase(input caseRec c, input int idx);
		string tag;
		tag = $sformatf("case %0d", idx);
		checkWord(out.rsData, c.expRs, {tag, " rsData"});
		checkWord(out.operandB, c.expOperandB, {tag, " operandB"});
		checkWord(out.imm, c.expImm, {tag, " imm"});
		checkWord(out.instr, c.instr, {tag, " instr"});
		checkWord(out.nextPc, c.nextPc, {tag, " nextPc"});
		checkReg(out.destReg, c.expDest, {tag, " destReg"});
		checkWord(truePc, c.expPc, {tag, " truePc"});
	endtask

	initial begin
		wait (loaded);
		#((cases.size() + 10) * clkPeriod * 2);
		$display("Timeout: the decode cases did not finish in time");
		failRun();
	end

	// Stop at the first failed property on decodeStage
	initial begin
		wait (decodeStage_inst.propsInst.failCount != 0);
		$display("An assertion on decodeStage failed at %0t", $time);
		failRun();
	end

	initial begin
		reset  = 1'b1;
		instr  = '0;
		nextPc = '0;
		rsFwd  = '0;
		rtFwd  = '0;
		ctrl   = '0;
		wb     = '0;
		readCases();
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		foreach (cases[i]) begin
			@(negedge clk);
			applyCase(cases[i]);
			#(clkPeriod / 2 - 1); // Just before the write edge
			if (!cases[i].isWrite) begin
				checkCase(cases[i], i);
			end
		end
		@(negedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/immExtend.sv
rtl/branchResolve.sv
rtl/decodeStage.sv
bench/decodeStage_props.sv
bench/decodeStageTb.sv

//--- bench/decodeCases.txt
# W addr data
# D instr nextPc imm zeroExt8 dest cond operandBImm forwardRs forwardRt branch jump pcBaseNext
#   branchImm11 rsFwd rtFwd, then expected rsData operandB imm destReg truePc
D 0543 0100 0 0 0 0 0 0 0 0 0 0 0 0000 0000 0000 0000 0003 2 0100
W 0 1000
W 1 1111
W 2 2222
W 3 8333
W 4 4444
W 5 a5a5
W 6 6666
W 7 fff0
D 0140 0102 0 0 0 0 0 0 0 0 0 0 0 0000 0000 1111 2222 0000 2 0102
D 039f 0104 0 0 0 0 0 0 0 0 0 0 0 0000 0000 8333 4444 ffff 4 0104
D 05d0 0106 0 0 0 0 0 0 0 0 0 0 0 0000 0000 a5a5 6666 fff0 6 0106
D 070f 0108 0 0 0 0 0 0 0 0 0 0 0 0000 0000 fff0 1000 000f 0 0108
D 00e0 010a 0 0 0 0 0 0 0 0 0 0 0 0000 0000 1000 fff0 0000 7 010a
D 0220 010c 0 0 0 0 0 0 0 0 0 0 0 0000 0000 2222 1111 0000 1 010c
D 0460 010e 0 0 0 0 0 0 0 0 0 0 0 0000 0000 4444 8333 0000 3 010e
D 06a0 0110 0 0 0 0 0 0 0 0 0 0 0 0000 0000 6666 a5a5 0000 5 0110
W 3 1234
D 0360 0112 0 0 0 0 0 0 0 0 0 0 0 0000 0000 1234 1234 0000 3 0112
D 0015 0200 0 0 0 0 1 0 0 0 0 0 0 0000 0000 1000 fff5 fff5 0 0200
D 0185 0202 1 0 0 0 1 0 0 0 0 0 0 0000 0000 1111 ff85 ff85 4 0202
D 027a 0204 1 0 0 0 1 0 0 0 0 0 0 0000 0000 2222 007a 007a 3 0204
D 0655 0206 2 0 0 0 1 0 0 0 0 0 0 0000 0000 6666 fe55 fe55 2 0206
D f3c1 0208 2 0 0 0 1 0 0 0 0 0 0 0000 0000 1234 03c1 03c1 6 0208
D 00fe 020a 3 0 0 0 1 0 0 0 0 0 0 0000 0000 1000 000e 000e 7 020a
D 00fe 020c 3 1 0 0 1 0 0 0 0 0 0 0000 0000 1000 00fe 00fe 7 020c
D 0140 0300 0 0 0 0 0 1 1 0 0 0 0 beef cafe beef cafe 0000 2 0300
D 0140 0302 0 0 0 0 0 1 0 0 0 0 0 beef cafe beef 2222 0000 2 0302
D 0140 0304 0 0 0 0 0 0 1 0 0 0 0 beef cafe 1111 cafe 0000 2 0304
D 0140 0306 0 0 0 0 0 1 0 0 1 0 0 9999 0000 9999 2222 0000 2 1151
D 0110 0400 0 0 0 0 0 1 0 1 0 1 0 0000 0000 0000 1000 fff0 0 0410
D 0110 0400 0 0 0 0 0 1 0 1 0 1 0 0005 0000 0005 1000 fff0 0 0400
D 0110 0400 0 0 0 1 0 1 0 1 0 1 0 0005 0000 0005 1000 fff0 0 0410
D 0110 0400 0 0 0 1 0 1 0 1 0 1 0 0000 0000 0000 1000 fff0 0 0400
D 0110 0400 0 0 0 2 0 1 0 1 0 1 0 8000 0000 8000 1000 fff0 0 0410
D 0110 0400 0 0 0 2 0 1 0 1 0 1 0 7fff 0000 7fff 1000 fff0 0 0400
D 0110 0400 0 0 0 3 0 1 0 1 0 1 0 0000 0000 0000 1000 fff0 0 0410
D 0110 0400 0 0 0 3 0 1 0 1 0 1 0 ffff 0000 ffff 1000 fff0 0 0400
D 01f0 0420 0 0 0 1 0 0 0 1 0 1 0 0000 0000 1111 fff0 fff0 7 0410
D 0110 0600 0 0 0 2 0 1 0 1 0 0 0 8001 0000 8001 1000 fff0 0 1121
D 0410 0800 0 0 3 0 0 0 0 0 1 1 1 0000 0000 4444 1000 fff0 7 0410
D 0320 0100 0 0 3 0 0 0 0 0 1 1 1 0000 0000 1234 1111 0000 7 0420
D 05fc 0500 0 0 3 0 0 0 0 0 1 0 0 0000 0000 a5a5 fff0 fffc 7 a5a1
D 0230 0500 0 0 3 0 0 0 0 0 1 0 1 0000 0000 2222 1111 fff0 7 2452
D 02a4 0700 0 0 0 0 0 0 0 0 0 0 0 0000 0000 2222 a5a5 0004 5 0700
D 02a4 0700 0 0 1 0 0 0 0 0 0 0 0 0000 0000 2222 a5a5 0004 1 0700
D 02a4 0700 0 0 2 0 0 0 0 0 0 0 0 0000 0000 2222 a5a5 0004 2 0700
D 02a4 0700 0 0 3 0 0 0 0 0 0 0 0 0000 0000 2222 a5a5 0004 7 0700
